// File: rtl/periph_pkg.sv
/* shared types and address map of the APB peripheral block
   CLK_MHZ and UART_DIV are scaled down for simulation */
`default_nettype none

package periph_pkg;

	// --------------------
	// sizes and timing
	localparam int N_HARTS  = 2;
	localparam int CLK_MHZ  = 4;    // clk cycles per mtime tick
	localparam int UART_DIV = 8;    // clk cycles per uart bit

	typedef logic [15:0]        paddr_t;
	typedef logic [31:0]        word_t;
	typedef logic [63:0]        mtime_t;
	typedef logic [7:0]         uart_byte_t;
	typedef logic [N_HARTS-1:0] hart_mask_t;

	// --------------------
	// address map
	localparam paddr_t TIMER_BASE = 16'h0000;
	localparam paddr_t UART_BASE  = 16'h4000;
	localparam paddr_t WIN_MASK   = 16'hc000;   // bits compared against a base

	// timer registers, low 6 address bits
	localparam logic [5:0] TMR_CTRL   = 6'h00;
	localparam logic [5:0] TMR_MSIP   = 6'h04;
	localparam logic [5:0] TMR_MTIME  = 6'h08;
	localparam logic [5:0] TMR_MTIMEH = 6'h0c;
	localparam logic [5:0] TMR_CMP0   = 6'h10;
	localparam logic [5:0] TMR_CMP0H  = 6'h14;
	localparam logic [5:0] TMR_CMP1   = 6'h18;
	localparam logic [5:0] TMR_CMP1H  = 6'h1c;

	// uart registers
	localparam logic [5:0] UART_DATA = 6'h00;
	localparam logic [5:0] UART_STAT = 6'h04;

	// --------------------
	// apb channels
	typedef struct packed {
		logic   psel;
		logic   penable;
		logic   pwrite;
		paddr_t paddr;
		word_t  pwdata;
	} apb_req_t;

	typedef struct packed {
		word_t prdata;
		logic  pready;
		logic  pslverr;
	} apb_rsp_t;

	// uart frame FSMs
	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} uart_tx_state_e;
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} uart_rx_state_e;

endpackage

`default_nettype wire

// File: rtl/apb_splitter.sv
/* purely combinational, adds no wait states
   accesses outside both windows complete here with pslverr */
`timescale 1ns/1ps
`default_nettype none

module apb_splitter
	import periph_pkg::*;
(
	input  apb_req_t i_apb,
	output apb_rsp_t o_apb,

	output apb_req_t o_timer_req,
	input  apb_rsp_t i_timer_rsp,

	output apb_req_t o_uart_req,
	input  apb_rsp_t i_uart_rsp
);

	// --------------------
	// window decode
	paddr_t win_addr;
	logic   hit_timer;
	logic   hit_uart;
	logic   miss_access;

	assign win_addr  = i_apb.paddr & WIN_MASK;
	assign hit_timer = (win_addr == TIMER_BASE);
	assign hit_uart  = (win_addr == UART_BASE);

	// access phase of a transfer nobody claims
	assign miss_access = i_apb.psel & i_apb.penable & ~hit_timer & ~hit_uart;

	// --------------------
	// request fan-out
	always_comb begin
		o_timer_req      = i_apb;
		o_timer_req.psel = i_apb.psel & hit_timer;

		o_uart_req      = i_apb;
		o_uart_req.psel = i_apb.psel & hit_uart;
	end

	// --------------------
	// response merge
	always_comb begin
		if (hit_timer) begin
			o_apb = i_timer_rsp;
		end else if (hit_uart) begin
			o_apb = i_uart_rsp;
		end else begin
			// answered locally, zero data
			o_apb.prdata  = '0;
			o_apb.pready  = 1'b1;
			o_apb.pslverr = miss_access;
		end
	end

endmodule

`default_nettype wire

// File: rtl/riscv_timer.sv
/* one mtime shared by N_HARTS harts, compare and msip per hart
   64-bit registers are accessed in 32-bit halves, not atomically */
`timescale 1ns/1ps
`default_nettype none

module riscv_timer
	import periph_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	input  apb_req_t   i_apb,
	output apb_rsp_t   o_apb,

	input  logic       i_dbg_halt,
	output hart_mask_t o_timer_irq,
	output hart_mask_t o_soft_irq
);

	localparam int PRE_W = (CLK_MHZ > 1) ? $clog2(CLK_MHZ) : 1;

	logic [PRE_W-1:0] pre_cnt;
	logic             tick;
	logic             count_en;

	logic             ctrl_en;
	hart_mask_t       msip;
	mtime_t           mtime;
	mtime_t           mtimecmp [N_HARTS];

	logic             apb_wr;
	logic [5:0]       reg_off;
	word_t            rdata;

	// --------------------
	// microsecond prescaler
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pre_cnt <= PRE_W'(CLK_MHZ - 1);
		end else if (tick) begin
			pre_cnt <= PRE_W'(CLK_MHZ - 1);
		end else begin
			pre_cnt <= pre_cnt - 1'b1;
		end
	end

	// one cycle in every CLK_MHZ
	assign tick = (pre_cnt == '0);

	// frozen while the debugger holds the harts
	assign count_en = tick & ctrl_en & ~i_dbg_halt;

	// --------------------
	// apb write decode
	assign apb_wr  = i_apb.psel & i_apb.penable & i_apb.pwrite;
	assign reg_off = i_apb.paddr[5:0];

	// control and soft irq bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en <= 1'b1;
			msip    <= '0;
		end else if (apb_wr) begin
			if (reg_off == TMR_CTRL)
				ctrl_en <= i_apb.pwdata[0];
			if (reg_off == TMR_MSIP)
				msip <= i_apb.pwdata[N_HARTS-1:0];
		end
	end

	// mtime, a write to either half wins over the tick
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
		end else if (apb_wr && reg_off == TMR_MTIME) begin
			mtime[31:0] <= i_apb.pwdata;
		end else if (apb_wr && reg_off == TMR_MTIMEH) begin
			mtime[63:32] <= i_apb.pwdata;
		end else if (count_en) begin
			mtime <= mtime + 1'b1;
		end
	end

	// compare values, all ones keeps the irq quiet after reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int h = 0; h < N_HARTS; h++) begin
				mtimecmp[h] <= '1;
			end
		end else if (apb_wr) begin
			case (reg_off)
				TMR_CMP0:  mtimecmp[0][31:0]  <= i_apb.pwdata;
				TMR_CMP0H: mtimecmp[0][63:32] <= i_apb.pwdata;
				TMR_CMP1:  mtimecmp[1][31:0]  <= i_apb.pwdata;
				TMR_CMP1H: mtimecmp[1][63:32] <= i_apb.pwdata;
				default: ;
			endcase
		end
	end

	// --------------------
	// read mux, unknown offsets read zero
	always_comb begin
		case (reg_off)
			TMR_CTRL:   rdata = word_t'(ctrl_en);
			TMR_MSIP:   rdata = word_t'(msip);
			TMR_MTIME:  rdata = mtime[31:0];
			TMR_MTIMEH: rdata = mtime[63:32];
			TMR_CMP0:   rdata = mtimecmp[0][31:0];
			TMR_CMP0H:  rdata = mtimecmp[0][63:32];
			TMR_CMP1:   rdata = mtimecmp[1][31:0];
			TMR_CMP1H:  rdata = mtimecmp[1][63:32];
			default:    rdata = '0;
		endcase
	end

	// no wait states, never an error
	assign o_apb = '{prdata: rdata, pready: 1'b1, pslverr: 1'b0};

	// --------------------
	// interrupts
	always_comb begin
		for (int h = 0; h < N_HARTS; h++) begin
			o_timer_irq[h] = (mtime >= mtimecmp[h]);
		end
	end

	assign o_soft_irq = msip;

endmodule

`default_nettype wire

// File: rtl/uart_mini.sv
/* 8N1 only, no flow control; one byte of receive buffering
   a write while the transmitter is busy is dropped, a new rx byte overwrites an unread one */
`timescale 1ns/1ps
`default_nettype none

module uart_mini
	import periph_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,

	input  apb_req_t i_apb,
	output apb_rsp_t o_apb,

	input  logic     i_uart_rx,
	output logic     o_uart_tx,
	output logic     o_uart_irq
);

	localparam int DIV_W = (UART_DIV > 1) ? $clog2(UART_DIV) : 1;

	logic [5:0]     reg_off;
	logic           wr_data;
	logic           rd_data;
	word_t          rdata;

	uart_tx_state_e tx_state;
	logic [DIV_W-1:0] tx_cnt;
	logic [2:0]     tx_idx;
	uart_byte_t     tx_shift;
	logic           tx_busy;

	uart_rx_state_e rx_state;
	logic [1:0]     rx_sync;
	logic           rx_prev;
	logic           rx_s;
	logic [DIV_W-1:0] rx_cnt;
	logic [2:0]     rx_idx;
	uart_byte_t     rx_shift;
	uart_byte_t     rx_data;
	logic           rx_valid;
	logic           rx_done;

	// --------------------
	// apb decode
	assign reg_off = i_apb.paddr[5:0];
	assign wr_data = i_apb.psel & i_apb.penable & i_apb.pwrite & (reg_off == UART_DATA);
	assign rd_data = i_apb.psel & i_apb.penable & ~i_apb.pwrite & (reg_off == UART_DATA);

	// --------------------
	// transmitter
	assign tx_busy = (tx_state != TX_IDLE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_state  <= TX_IDLE;
			tx_cnt    <= '0;
			tx_idx    <= '0;
			o_uart_tx <= 1'b1;
		end else begin
			if (tx_state != TX_IDLE)
				tx_cnt <= tx_cnt - 1'b1;
			case (tx_state)
				TX_IDLE: if (wr_data) begin
					// start bit on the next cycle
					tx_state  <= TX_START;
					tx_cnt    <= DIV_W'(UART_DIV - 1);
					o_uart_tx <= 1'b0;
				end
				TX_START: if (tx_cnt == '0) begin
					tx_state  <= TX_DATA;
					tx_cnt    <= DIV_W'(UART_DIV - 1);
					tx_idx    <= '0;
					o_uart_tx <= tx_shift[0];
				end
				TX_DATA: if (tx_cnt == '0) begin
					tx_cnt <= DIV_W'(UART_DIV - 1);
					tx_idx <= tx_idx + 1'b1;
					if (tx_idx == 3'd7) begin
						tx_state  <= TX_STOP;
						o_uart_tx <= 1'b1;
					end else begin
						o_uart_tx <= tx_shift[1];
					end
				end
				TX_STOP: if (tx_cnt == '0)
					tx_state <= TX_IDLE;
				default: tx_state <= TX_IDLE;
			endcase
		end
	end

	// lsb first, shifted once per data bit
	always_ff @(posedge clk) begin
		if (tx_state == TX_IDLE && wr_data)
			tx_shift <= i_apb.pwdata[7:0];
		else if (tx_state == TX_DATA && tx_cnt == '0)
			tx_shift <= tx_shift >> 1;
	end

	// --------------------
	// receiver
	assign rx_s    = rx_sync[1];
	assign rx_done = (rx_state == RX_STOP) && (rx_cnt == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_sync  <= 2'b11;
			rx_prev  <= 1'b1;
			rx_state <= RX_IDLE;
			rx_cnt   <= '0;
			rx_idx   <= '0;
			rx_valid <= 1'b0;
		end else begin
			// two-flop synchronizer
			rx_sync <= {rx_sync[0], i_uart_rx};
			rx_prev <= rx_s;
			if (rx_state != RX_IDLE)
				rx_cnt <= rx_cnt - 1'b1;
			case (rx_state)
				RX_IDLE: if (rx_prev && !rx_s) begin
					// half a bit to reach mid start bit
					rx_state <= RX_START;
					rx_cnt   <= DIV_W'(UART_DIV / 2 - 1);
				end
				RX_START: if (rx_cnt == '0) begin
					rx_cnt <= DIV_W'(UART_DIV - 1);
					rx_idx <= '0;
					// high again means a glitch
					rx_state <= rx_s ? RX_IDLE : RX_DATA;
				end
				RX_DATA: if (rx_cnt == '0) begin
					rx_cnt <= DIV_W'(UART_DIV - 1);
					rx_idx <= rx_idx + 1'b1;
					if (rx_idx == 3'd7)
						rx_state <= RX_STOP;
				end
				RX_STOP: if (rx_cnt == '0)
					rx_state <= RX_IDLE;
				default: rx_state <= RX_IDLE;
			endcase
			// new byte beats a read in the same cycle
			if (rx_done)
				rx_valid <= 1'b1;
			else if (rd_data)
				rx_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rx_state == RX_DATA && rx_cnt == '0)
			rx_shift <= {rx_s, rx_shift[7:1]};
		if (rx_done)
			rx_data <= rx_shift;
	end

	// --------------------
	// register read
	always_comb begin
		case (reg_off)
			UART_DATA: rdata = word_t'(rx_data);
			UART_STAT: rdata = word_t'({rx_valid, tx_busy});
			default:   rdata = '0;
		endcase
	end

	assign o_apb      = '{prdata: rdata, pready: 1'b1, pslverr: 1'b0};
	assign o_uart_irq = rx_valid;

endmodule

`default_nettype wire

// File: rtl/periph_apb_top.sv
/* APB peripheral side: splitter, machine timer and UART
   expects a zero-wait-state APB requester, pready is tied high */
`timescale 1ns/1ps
`default_nettype none

module periph_apb_top
	import periph_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	input  apb_req_t   i_apb,
	output apb_rsp_t   o_apb,

	input  logic       i_dbg_halt,
	output hart_mask_t o_timer_irq,
	output hart_mask_t o_soft_irq,

	input  logic       i_uart_rx,
	output logic       o_uart_tx,
	output logic       o_uart_irq
);

	// per-window apb channels
	apb_req_t timer_req;
	apb_rsp_t timer_rsp;
	apb_req_t uart_req;
	apb_rsp_t uart_rsp;

	// --------------------
	// address split
	apb_splitter u_splitter (
		.i_apb       (i_apb),
		.o_apb       (o_apb),
		.o_timer_req (timer_req),
		.i_timer_rsp (timer_rsp),
		.o_uart_req  (uart_req),
		.i_uart_rsp  (uart_rsp)
	);

	// --------------------
	// peripherals
	riscv_timer u_timer (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_apb       (timer_req),
		.o_apb       (timer_rsp),
		.i_dbg_halt  (i_dbg_halt),
		.o_timer_irq (o_timer_irq),
		.o_soft_irq  (o_soft_irq)
	);

	uart_mini u_uart (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_apb      (uart_req),
		.o_apb      (uart_rsp),
		.i_uart_rx  (i_uart_rx),
		.o_uart_tx  (o_uart_tx),
		.o_uart_irq (o_uart_irq)
	);

endmodule

`default_nettype wire

// File: verif/periph_chk.sv
/* protocol and reset checks on periph_apb_top
   assumes a zero-wait-state requester */
`timescale 1ns/1ps
`default_nettype none

module periph_chk
	import periph_pkg::*;
(
	input logic       clk,
	input logic       rst_n,
	input apb_req_t   i_apb_req,
	input apb_rsp_t   i_apb_rsp,
	input logic       i_uart_tx,
	input hart_mask_t i_timer_irq,
	input hart_mask_t i_soft_irq,
	input logic       i_uart_irq
);

	logic stat_rd;

	// access cycle of a uart status read
	assign stat_rd = i_apb_req.psel && i_apb_req.penable && !i_apb_req.pwrite &&
		(i_apb_req.paddr == (UART_BASE | paddr_t'(UART_STAT)));

	// --------------------
	// apb response
	// every access completes at once
	a_pready: assert property (@(posedge clk) disable iff (!rst_n)
		i_apb_req.psel && i_apb_req.penable |-> i_apb_rsp.pready)
		else $error("pready low in an access cycle");

	// errors only outside both windows
	a_slverr: assert property (@(posedge clk) disable iff (!rst_n)
		i_apb_rsp.pslverr |-> i_apb_req.paddr >= paddr_t'(16'h8000))
		else $error("pslverr inside a peripheral window");

	// --------------------
	// reset and interrupts
	a_reset_state: assert property (@(posedge clk)
		$rose(rst_n) |-> i_uart_tx && i_timer_irq == '0 && i_soft_irq == '0)
		else $error("outputs not at reset values after reset release");

	// irq pin agrees with the rx valid bit seen on the bus
	a_uart_irq: assert property (@(posedge clk) disable iff (!rst_n)
		stat_rd |-> i_apb_rsp.prdata[1] == i_uart_irq)
		else $error("uart irq and rx valid status bit disagree");

endmodule

bind periph_apb_top periph_chk u_chk (
	.clk         (clk),
	.rst_n       (rst_n),
	.i_apb_req   (i_apb),
	.i_apb_rsp   (o_apb),
	.i_uart_tx   (o_uart_tx),
	.i_timer_irq (o_timer_irq),
	.i_soft_irq  (o_soft_irq),
	.i_uart_irq  (o_uart_irq)
);

`default_nettype wire

// File: verif/tb_periph.sv
/* directed testbench for periph_apb_top, uart tx looped back to rx
   register traffic assumes one idle cycle between apb transfers */
`timescale 1ns/1ps
`default_nettype none

module tb_periph
	import periph_pkg::*;
();

	// --------------------
	// run length
	localparam int FRAME_CYCLES   = 10 * UART_DIV;
	localparam int REG_CYCLES     = 1200;
	// five frames, about 100 timer ticks and the register traffic, doubled
	localparam int TIMEOUT_CYCLES = 2 * (5 * FRAME_CYCLES + 100 * CLK_MHZ + REG_CYCLES);
	localparam int SEED           = 32'hbb76;

	logic       clk;
	logic       rst_n;
	apb_req_t   apb_req;
	apb_rsp_t   apb_rsp;
	logic       dbg_halt;
	hart_mask_t timer_irq;
	hart_mask_t soft_irq;
	logic       uart_line;
	logic       uart_irq;

	int cycle_cnt;
	int test_cnt;
	int check_cnt;
	int err_cnt;

	// tx drives rx directly
	periph_apb_top uut (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_apb       (apb_req),
		.o_apb       (apb_rsp),
		.i_dbg_halt  (dbg_halt),
		.o_timer_irq (timer_irq),
		.o_soft_irq  (soft_irq),
		.i_uart_rx   (uart_line),
		.o_uart_tx   (uart_line),
		.o_uart_irq  (uart_irq)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run still going after %0d cycles", cycle_cnt);
			$display("Errors found");
			$finish;
		end
	end

	// --------------------
	// bus and reset
	function automatic paddr_t tmr_reg(input logic [5:0] off);
		return TIMER_BASE | paddr_t'(off);
	endfunction

	function automatic paddr_t uart_reg(input logic [5:0] off);
		return UART_BASE | paddr_t'(off);
	endfunction

	task automatic apply_reset();
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	// setup, access, then back to idle
	task automatic apb_xfer(input logic wr, input paddr_t addr, input word_t wdata,
		output word_t rdata, output logic err);
		@(posedge clk);
		#1;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = wr;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(posedge clk);
		#1;
		apb_req.penable = 1'b1;
		// response is combinational in the access cycle
		#1;
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(posedge clk);
		#1;
		apb_req = '0;
	endtask

	task automatic apb_write(input paddr_t addr, input word_t data);
		word_t rd;
		logic  err;
		apb_xfer(1'b1, addr, data, rd, err);
		check_bit("pslverr", 1'b0, err);
	endtask

	task automatic apb_read(input paddr_t addr, output word_t data, output logic err);
		apb_xfer(1'b0, addr, '0, data, err);
	endtask

	// --------------------
	// compare tasks
	task automatic check_word(input string name, input word_t exp, input word_t act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("ERR %0s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic check_time(input string name, input mtime_t lo, input mtime_t hi,
		input mtime_t act);
		check_cnt++;
		if (act < lo || act > hi) begin
			err_cnt++;
			$display("ERR %0s: expected %h to %h, got %h", name, lo, hi, act);
		end
	endtask

	task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("ERR %0s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic check_mask(input string name, input hart_mask_t exp, input hart_mask_t act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("ERR %0s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("ERR %0s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_cnt++;
		if (err_cnt == errs_before)
			$display("test %0s: pass", name);
		else
			$display("test %0s: %0d mismatches", name, err_cnt - errs_before);
	endtask

	// --------------------
	// tests
	task automatic test_decode();
		int    errs;
		word_t rd;
		logic  err;
		errs = err_cnt;
		// above 0x8000 nobody answers
		apb_read(16'h8004, rd, err);
		check_bit("pslverr", 1'b1, err);
		check_word("prdata", 32'h0, rd);
		apb_read(16'hc000, rd, err);
		check_bit("pslverr", 1'b1, err);
		check_word("prdata", 32'h0, rd);
		// enable bit resets to one
		apb_read(tmr_reg(TMR_CTRL), rd, err);
		check_bit("pslverr", 1'b0, err);
		check_word("tmr_ctrl", 32'h1, rd);
		report_test("decode", errs);
	endtask

	task automatic test_mtime_count();
		int     errs;
		mtime_t now;
		word_t  hi_val;
		word_t  rd;
		logic   err;
		errs = err_cnt;
		apb_write(tmr_reg(TMR_MTIMEH), '0);
		apb_write(tmr_reg(TMR_MTIME), '0);
		repeat (40 * CLK_MHZ) @(posedge clk);
		apb_read(tmr_reg(TMR_MTIME), rd, err);
		now[31:0] = rd;
		apb_read(tmr_reg(TMR_MTIMEH), rd, err);
		now[63:32] = rd;
		// 40 ticks give or take one
		check_time("mtime", 64'd39, 64'd41, now);
		hi_val = $urandom;
		apb_write(tmr_reg(TMR_MTIMEH), hi_val);
		apb_read(tmr_reg(TMR_MTIMEH), rd, err);
		check_word("mtimeh", hi_val, rd);
		report_test("mtime count", errs);
	endtask

	task automatic test_freeze();
		int    errs;
		word_t first;
		word_t second;
		logic  err;
		errs = err_cnt;
		// debug halt
		@(posedge clk);
		#1;
		dbg_halt = 1'b1;
		apb_read(tmr_reg(TMR_MTIME), first, err);
		repeat (20) @(posedge clk);
		apb_read(tmr_reg(TMR_MTIME), second, err);
		check_word("mtime halted", first, second);
		@(posedge clk);
		#1;
		dbg_halt = 1'b0;
		// enable cleared
		apb_write(tmr_reg(TMR_CTRL), 32'h0);
		apb_read(tmr_reg(TMR_MTIME), first, err);
		repeat (20) @(posedge clk);
		apb_read(tmr_reg(TMR_MTIME), second, err);
		check_word("mtime disabled", first, second);
		// counting again
		apb_write(tmr_reg(TMR_CTRL), 32'h1);
		apb_read(tmr_reg(TMR_MTIME), first, err);
		repeat (20) @(posedge clk);
		apb_read(tmr_reg(TMR_MTIME), second, err);
		check_bit("mtime advancing", 1'b1, second > first);
		report_test("freeze", errs);
	endtask

	task automatic test_hart_irq();
		int    errs;
		word_t lo;
		word_t rd;
		logic  err;
		errs = err_cnt;
		apply_reset();
		check_mask("o_timer_irq", 2'b00, timer_irq);
		check_mask("o_soft_irq", 2'b00, soft_irq);
		check_bit("o_uart_tx", 1'b1, uart_line);
		apb_read(tmr_reg(TMR_MTIMEH), rd, err);
		check_word("mtimeh", 32'h0, rd);
		apb_read(tmr_reg(TMR_MTIME), lo, err);
		// high half first so hart 0 stays quiet meanwhile
		apb_write(tmr_reg(TMR_CMP0H), 32'h0);
		apb_write(tmr_reg(TMR_CMP0), lo + 32'd5);
		check_mask("o_timer_irq", 2'b00, timer_irq);
		repeat (10 * CLK_MHZ) @(posedge clk);
		#1;
		// compare 1 still all ones
		check_mask("o_timer_irq", 2'b01, timer_irq);
		apb_write(tmr_reg(TMR_MSIP), 32'h2);
		check_mask("o_soft_irq", 2'b10, soft_irq);
		report_test("hart irq", errs);
	endtask

	task automatic test_uart_loopback();
		int         errs;
		uart_byte_t tx_byte;
		word_t      rd;
		logic       err;
		errs = err_cnt;
		for (int i = 0; i < 4; i++) begin
			tx_byte = uart_byte_t'($urandom);
			apb_write(uart_reg(UART_DATA), word_t'(tx_byte));
			apb_read(uart_reg(UART_STAT), rd, err);
			check_bit("tx busy", 1'b1, rd[0]);
			// wait for the stop bit sample
			do begin
				apb_read(uart_reg(UART_STAT), rd, err);
			end while (!rd[1]);
			check_bit("o_uart_irq", 1'b1, uart_irq);
			apb_read(uart_reg(UART_DATA), rd, err);
			check_byte("rx data", tx_byte, rd[7:0]);
			apb_read(uart_reg(UART_STAT), rd, err);
			check_bit("rx valid", 1'b0, rd[1]);
			check_bit("o_uart_irq", 1'b0, uart_irq);
			// tx still in its stop bit
			while (rd[0])
				apb_read(uart_reg(UART_STAT), rd, err);
		end
		report_test("uart loopback", errs);
	endtask

	// --------------------
	// main sequence
	initial begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		apb_req   = '0;
		dbg_halt  = 1'b0;
		cycle_cnt = 0;
		test_cnt  = 0;
		check_cnt = 0;
		err_cnt   = 0;
		void'($urandom(SEED));
		apply_reset();

		test_decode();
		test_mtime_count();
		test_freeze();
		test_hart_irq();
		test_uart_loopback();

		$display("%0d tests, %0d checks, %0d mismatches", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
rtl/periph_pkg.sv
rtl/apb_splitter.sv
rtl/riscv_timer.sv
rtl/uart_mini.sv
rtl/periph_apb_top.sv
verif/periph_chk.sv
verif/tb_periph.sv

// File: Bender.yml
package:
  name: periph_apb

sources:
  # design, package first
  - rtl/periph_pkg.sv
  - rtl/apb_splitter.sv
  - rtl/riscv_timer.sv
  - rtl/uart_mini.sv
  - rtl/periph_apb_top.sv

  # verification only
  - target: test
    files:
      - verif/periph_chk.sv
      - verif/tb_periph.sv
